// File: src/icache_pkg.sv
package icache_pkg;

	// fetch and memory address width
	localparam int addr_bits = 32;

	// a line is 64 bytes
	localparam int offset_bits = 6;

	// direct mapped over 8 lines
	localparam int index_bits = 3;
	localparam int num_lines = 1 << index_bits;

	// whatever is left above index and offset
	localparam int tag_bits = addr_bits - index_bits - offset_bits;

	// refill burst of 64-bit beats
	localparam int beat_bits = 3;
	localparam int beats_per_line = 1 << beat_bits;
	localparam int beat_width = 64;

	// fetch returns one 32-bit half of a doubleword
	localparam int word_bits = 32;
	localparam int half_sel_bit = 2;

	// lowest address bit of the doubleword index inside a line
	localparam int dword_lsb = offset_bits - beat_bits;

	// data store is addressed by {line, doubleword}
	localparam int store_addr_bits = index_bits + beat_bits;
	localparam int store_depth = num_lines * beats_per_line;

	// controller FSM
	typedef enum logic [1:0] {
		idle,
		respond,
		fetch,
		commit
	} ctrl_state_t;

endpackage

// File: src/icache_tag_store.sv
`timescale 1ns/10ps

module icache_tag_store
	import icache_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic [addr_bits-1:0] req_addr,
	input  logic                 fill_done,
	output logic                 hit
);

	// one valid bit and one tag per line
	logic [num_lines-1:0] valid;
	logic [tag_bits-1:0]  tags [num_lines];

	logic [index_bits-1:0] line_index;
	logic [tag_bits-1:0]   req_tag;
	logic                  tag_match;

	// split the request address
	assign line_index = req_addr[offset_bits +: index_bits];
	assign req_tag = req_addr[addr_bits-1 -: tag_bits];

	// lookup is purely combinational so the controller sees it in the same cycle
	assign tag_match = (tags[line_index] == req_tag);
	assign hit = valid[line_index] & tag_match;

	// reset invalidates every line
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
		end else if (fill_done) begin
			valid[line_index] <= 1'b1;
		end
	end

	// tag is taken from the request that caused the refill
	always_ff @(posedge clk) begin
		if (fill_done) begin
			tags[line_index] <= req_tag;
		end
	end

endmodule

// File: src/icache_data_store.sv
`timescale 1ns/10ps

module icache_data_store
	import icache_pkg::*;
(
	input  logic                  clk,
	input  logic [addr_bits-1:0]  req_addr,
	input  logic                  fill_wen,
	input  logic [beat_bits-1:0]  fill_beat,
	input  logic [beat_width-1:0] mem_data,
	output logic [word_bits-1:0]  data
);

	// 8 lines of 8 doublewords
	logic [beat_width-1:0] mem [store_depth];

	logic [index_bits-1:0]      line_index;
	logic [beat_bits-1:0]       req_dword;
	logic [store_addr_bits-1:0] wr_addr;
	logic [store_addr_bits-1:0] rd_addr;
	logic [beat_width-1:0]      rd_dword;
	logic [word_bits-1:0]       rd_word;

	assign line_index = req_addr[offset_bits +: index_bits];
	assign req_dword = req_addr[dword_lsb +: beat_bits];

	// refill writes beat by beat into the requested line
	assign wr_addr = {line_index, fill_beat};

	// normal lookup reads the doubleword holding the fetch address
	assign rd_addr = {line_index, req_dword};
	assign rd_dword = mem[rd_addr];

	// bit 2 picks the upper or lower word
	assign rd_word = req_addr[half_sel_bit] ? rd_dword[beat_width-1 -: word_bits]
	                                        : rd_dword[word_bits-1:0];

	always_ff @(posedge clk) begin
		if (fill_wen) begin
			mem[wr_addr] <= mem_data;
		end
	end

	// one cycle of read latency that lines up with the respond state
	always_ff @(posedge clk) begin
		if (!fill_wen) begin
			data <= rd_word;
		end
	end

endmodule

// File: src/icache_controller.sv
`timescale 1ns/10ps

module icache_controller
	import icache_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 req_valid,
	input  logic [addr_bits-1:0] req_addr,
	input  logic                 hit,
	input  logic                 mem_ready,
	input  logic                 mem_last,
	output logic                 data_ok,
	output logic                 mem_valid,
	output logic [addr_bits-1:0] mem_addr,
	output logic                 fill_wen,
	output logic                 fill_done,
	output logic [beat_bits-1:0] fill_beat
);

	ctrl_state_t state;
	ctrl_state_t state_next;

	// counts accepted beats of the current refill
	logic [beat_bits-1:0] beat;
	logic [beat_bits-1:0] beat_next;

	logic beat_accept;

	// a beat moves only when the memory is ready during a burst
	assign beat_accept = (state == fetch) & mem_ready;

	always_comb begin
		state_next = state;
		beat_next = beat;

		case (state)
			idle: begin
				if (req_valid) begin
					if (hit) begin
						// data store read is already in flight
						state_next = respond;
					end else begin
						state_next = fetch;
						beat_next = '0;
					end
				end
			end

			respond: begin
				state_next = idle;
			end

			fetch: begin
				if (mem_ready) begin
					beat_next = beat + 1'b1;
					if (mem_last) begin
						state_next = commit;
						beat_next = '0;
					end
				end
			end

			commit: begin
				// tag goes valid here so the held request hits on return to idle
				state_next = idle;
			end

			default: begin
				state_next = idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			beat <= '0;
		end else begin
			state <= state_next;
			beat <= beat_next;
		end
	end

	// fetch port
	assign data_ok = (state == respond);

	// memory port address is line aligned and held by the request
	assign mem_valid = (state == fetch);
	assign mem_addr = {req_addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};

	// data store write strobe follows the accepted beat
	assign fill_wen = beat_accept;
	assign fill_beat = beat;

	// tag commit one cycle after the last beat
	assign fill_done = (state == commit);

endmodule

// File: src/icache_top.sv
`timescale 1ns/10ps

module icache_top
	import icache_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,

	// fetch port
	input  logic                  req_valid,
	input  logic [addr_bits-1:0]  req_addr,
	output logic                  data_ok,
	output logic [word_bits-1:0]  data,

	// burst memory port
	output logic                  mem_valid,
	output logic [addr_bits-1:0]  mem_addr,
	input  logic                  mem_ready,
	input  logic                  mem_last,
	input  logic [beat_width-1:0] mem_data
);

	logic                 hit;
	logic                 fill_done;
	logic                 fill_wen;
	logic [beat_bits-1:0] fill_beat;

	icache_tag_store u_tag_store (
		.clk       (clk),
		.reset     (reset),
		.req_addr  (req_addr),
		.fill_done (fill_done),
		.hit       (hit)
	);

	icache_data_store u_data_store (
		.clk       (clk),
		.req_addr  (req_addr),
		.fill_wen  (fill_wen),
		.fill_beat (fill_beat),
		.mem_data  (mem_data),
		.data      (data)
	);

	icache_controller u_controller (
		.clk       (clk),
		.reset     (reset),
		.req_valid (req_valid),
		.req_addr  (req_addr),
		.hit       (hit),
		.mem_ready (mem_ready),
		.mem_last  (mem_last),
		.data_ok   (data_ok),
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.fill_wen  (fill_wen),
		.fill_done (fill_done),
		.fill_beat (fill_beat)
	);

endmodule

// File: tests/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
	output logic clk
);

	localparam int half_period = 50;

	logic clk_q = 1'b0;

	// 100 ns period
	always #(half_period) clk_q = ~clk_q;

	assign clk = clk_q;

endmodule

// File: tests/mem_model.sv
`timescale 1ns/10ps

module mem_model
	import icache_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  mem_valid,
	input  logic [addr_bits-1:0]  mem_addr,
	output logic                  mem_ready,
	output logic                  mem_last,
	output logic [beat_width-1:0] mem_data,
	output int                    burst_count,
	output logic [addr_bits-1:0]  last_line
);

	integer seed = 67716;

	logic                  ready_q = 1'b0;
	logic                  last_q = 1'b0;
	logic [beat_width-1:0] data_q = '0;
	logic [beat_bits-1:0]  beat = '0;
	logic                  valid_prev = 1'b0;
	logic [addr_bits-1:0]  base;
	int                    bursts = 0;
	logic [addr_bits-1:0]  line_q = '0;

	always @(posedge clk) begin
		if (reset) begin
			beat = '0;
			valid_prev = 1'b0;
		end else begin
			// a new burst starts on the rising edge of mem_valid
			if (mem_valid && !valid_prev) begin
				bursts = bursts + 1;
				line_q = mem_addr;
			end
			if (mem_valid && ready_q) begin
				beat = last_q ? '0 : beat + 1'b1;
			end
			valid_prev = mem_valid;
		end
		#1;
		ready_q = mem_valid && (($random(seed) & 3) != 0);
		last_q = (beat == beat_bits'(beats_per_line - 1));
		// low word at L+8k, high word at L+8k+4
		base = mem_addr + {26'd0, beat, 3'd0};
		data_q = {base + 32'd4, base};
	end

	assign mem_ready = ready_q;
	assign mem_last = last_q;
	assign mem_data = data_q;
	assign burst_count = bursts;
	assign last_line = line_q;

endmodule

// File: tests/icache_checker.sv
`timescale 1ns/10ps

module icache_checker
	import icache_pkg::*;
(
	input logic                 clk,
	input logic                 reset,
	input ctrl_state_t          state,
	input logic                 data_ok,
	input logic                 mem_valid,
	input logic [addr_bits-1:0] mem_addr,
	input logic                 mem_ready,
	input logic                 mem_last,
	input logic                 fill_done
);

	data_ok_single: assert property (@(posedge clk) disable iff (reset)
		data_ok |=> !data_ok) else $error("data_ok high for two cycles");

	// address must hold until the last beat is taken
	mem_addr_stable: assert property (@(posedge clk) disable iff (reset)
		mem_valid && !(mem_ready && mem_last) |=> $stable(mem_addr))
		else $error("mem_addr changed during a burst");

	no_overlap: assert property (@(posedge clk) disable iff (reset)
		!(mem_valid && data_ok)) else $error("mem_valid and data_ok high together");

	commit_after_last: assert property (@(posedge clk) disable iff (reset)
		mem_valid && mem_ready && mem_last |=> fill_done)
		else $error("fill_done missing after the last beat");

	// the held request must hit once its tag is committed
	hit_after_commit: assert property (@(posedge clk) disable iff (reset)
		$past(state == commit, 2) |-> data_ok)
		else $error("held request did not hit after the refill");

endmodule

// File: tests/icache_tb.sv
`timescale 1ns/10ps

module icache_tb
	import icache_pkg::*;
();

	localparam int clk_period = 100;
	localparam int reset_cycles = 8;
	localparam int drive_delay = 1;
	localparam int num_tests = 16;

	// one row per test with name, fetch address and expected hit
	string test_name [num_tests] = '{
		"cold_miss", "hit_upper_half", "hit_beat5", "hit_beat7",
		"other_index", "conflict_a", "conflict_b", "conflict_a_again",
		"other_index_kept", "conflict_b_again", "conflict_b_hit", "high_tag_miss",
		"refill_beat1", "refill_beat3", "refill_beat6", "other_index_end"
	};
	logic [31:0] test_addr [num_tests] = '{
		32'h0000_1000, 32'h0000_1004, 32'h0000_1028, 32'h0000_103c,
		32'h0000_1040, 32'h0000_1200, 32'h0000_1010, 32'h0000_1208,
		32'h0000_1044, 32'h0000_1020, 32'h0000_103c, 32'h8000_0180,
		32'h8000_0188, 32'h8000_019c, 32'h8000_01b4, 32'h0000_107c
	};
	bit test_hit [num_tests] = '{
		1'b0, 1'b1, 1'b1, 1'b1,
		1'b0, 1'b0, 1'b0, 1'b0,
		1'b1, 1'b0, 1'b1, 1'b0,
		1'b1, 1'b1, 1'b1, 1'b1
	};

	logic        clk;
	logic        reset;
	logic        req_valid;
	logic [31:0] req_addr;
	logic        data_ok;
	logic [31:0] data;
	logic        mem_valid;
	logic [31:0] mem_addr;
	logic        mem_ready;
	logic        mem_last;
	logic [63:0] mem_data;
	int          burst_count;
	logic [31:0] last_line;

	int pass_count = 0;
	int fail_count = 0;
	int test_errors = 0;

	clock_gen u_clock (.clk(clk));

	mem_model u_mem (
		.clk         (clk),
		.reset       (reset),
		.mem_valid   (mem_valid),
		.mem_addr    (mem_addr),
		.mem_ready   (mem_ready),
		.mem_last    (mem_last),
		.mem_data    (mem_data),
		.burst_count (burst_count),
		.last_line   (last_line)
	);

	icache_top dut (
		.clk       (clk),
		.reset     (reset),
		.req_valid (req_valid),
		.req_addr  (req_addr),
		.data_ok   (data_ok),
		.data      (data),
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.mem_ready (mem_ready),
		.mem_last  (mem_last),
		.mem_data  (mem_data)
	);

	bind icache_controller icache_checker u_checker (
		.clk       (clk),
		.reset     (reset),
		.state     (state),
		.data_ok   (data_ok),
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.mem_ready (mem_ready),
		.mem_last  (mem_last),
		.fill_done (fill_done)
	);

	task automatic check_value(input string test, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error %s %s: expected %h, actual %h", test, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string test);
		if (test_errors == 0) begin
			pass_count++;
			$display("test %s ok", test);
		end else begin
			fail_count++;
			$display("test %s failed with %0d errors", test, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic run_test(input int i);
		logic [31:0] addr;
		int          start_bursts;
		int          cycles;
		begin
			addr = test_addr[i];
			start_bursts = burst_count;
			@(posedge clk);
			#drive_delay;
			req_valid = 1'b1;
			req_addr = addr;
			cycles = 0;
			@(negedge clk);
			while (!data_ok) begin
				@(negedge clk);
				cycles++;
			end
			// every word holds its own word-aligned address
			check_value(test_name[i], "data", addr & ~32'h3, data);
			check_value(test_name[i], "bursts", test_hit[i] ? 32'd0 : 32'd1,
				burst_count - start_bursts);
			if (test_hit[i]) begin
				check_value(test_name[i], "hit latency", 32'd1, cycles);
			end else begin
				check_value(test_name[i], "mem_addr", addr & ~32'h3f, last_line);
			end
			finish_test(test_name[i]);
		end
	endtask

	initial begin
		#((num_tests * 64 + 100) * clk_period);
		$display("timeout: the cache stopped answering fetch requests");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		reset = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		repeat (reset_cycles) @(posedge clk);
		#drive_delay;
		reset = 1'b0;
		@(negedge clk);
		check_value("reset", "data_ok", 32'd0, {31'd0, data_ok});
		check_value("reset", "mem_valid", 32'd0, {31'd0, mem_valid});
		finish_test("reset");
		for (int i = 0; i < num_tests; i++) begin
			run_test(i);
		end
		@(posedge clk);
		#drive_delay;
		req_valid = 1'b0;
		repeat (2) @(posedge clk);
		$display("tests passed: %0d failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: icache_top.f
src/icache_pkg.sv
src/icache_tag_store.sv
src/icache_data_store.sv
src/icache_controller.sv
src/icache_top.sv
tests/clock_gen.sv
tests/mem_model.sv
tests/icache_checker.sv
tests/icache_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS := --binary --timing --assert
TOP := icache_tb
FILELIST := icache_top.f
OBJ_DIR := obj_dir
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
